/* filelist.f */
logic/sys_pkg.sv
logic/periph_bus_if.sv
logic/bus_decoder.sv
logic/work_ram.sv
logic/palette_ram.sv
logic/cabinet_io.sv
logic/vdp_cmd.sv
logic/main_bus_sys.sv
verif/tb_main_bus_sys.sv

/* logic/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
    import sys_pkg::*;
(
    input  logic              clk96,
    input  logic              reset96,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [1:0]        sel,
    input  logic [ADDR_W-1:1] adr,
    input  logic [DATA_W-1:0] dat_w,
    output logic [DATA_W-1:0] dat_r,
    output logic              ack,
    periph_bus_if.master      wram,
    periph_bus_if.master      pal,
    periph_bus_if.master      io,
    periph_bus_if.master      vdp
);

    bus_addr_u baddr;
    logic      open_req;     // cycle open, no ack given yet
    logic      hit_wram;
    logic      hit_pal;
    logic      hit_io;
    logic      hit_vdp;
    logic      unmapped_ack;

    assign baddr    = {adr, 1'b0};  // byte address, bit 0 always clear
    assign open_req = cyc && stb && !ack;

    assign hit_wram = baddr.rgn.region == REGION_WRAM;
    assign hit_vdp  = baddr.rgn.region[7:4] == REGION_VDP;
    assign hit_pal  = baddr.rgn.region[7:4] == REGION_PAL;
    assign hit_io   = baddr.rgn.region == IO_PAGE[11:4];  // full page checked in cabinet_io

    assign wram.stb  = open_req && hit_wram;
    assign wram.we   = we;
    assign wram.sel  = sel;
    assign wram.adr  = baddr;
    assign wram.wdat = dat_w;

    assign pal.stb  = open_req && hit_pal;
    assign pal.we   = we;
    assign pal.sel  = sel;
    assign pal.adr  = baddr;
    assign pal.wdat = dat_w;

    assign io.stb  = open_req && hit_io;
    assign io.we   = we;
    assign io.sel  = sel;
    assign io.adr  = baddr;
    assign io.wdat = dat_w;

    assign vdp.stb  = open_req && hit_vdp;
    assign vdp.we   = we;
    assign vdp.sel  = sel;
    assign vdp.adr  = baddr;
    assign vdp.wdat = dat_w;

    // nobody home, answer ourselves with zero data
    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            unmapped_ack <= 1'b0;
        end else begin
            unmapped_ack <= open_req && !(hit_wram || hit_pal || hit_io || hit_vdp);
        end
    end

    // targets keep rdat and ack low when idle, so a plain OR merges them
    assign ack   = wram.ack | pal.ack | io.ack | vdp.ack | unmapped_ack;
    assign dat_r = wram.rdat | pal.rdat | io.rdat | vdp.rdat;

    a_one_target: assert property (@(posedge clk96) disable iff (reset96)
        $onehot0({wram.stb, pal.stb, io.stb, vdp.stb}))
        else $error("more than one target strobed");

    a_ack_in_cycle: assert property (@(posedge clk96) disable iff (reset96)
        ack |-> cyc && stb)
        else $error("ack outside an open bus cycle");

endmodule

/* logic/cabinet_io.sv */
`timescale 1ns/1ps

module cabinet_io
    import sys_pkg::*;
(
    input  logic         clk96,
    input  logic         reset96,
    input  joy_t         joy1,
    input  joy_t         joy2,
    input  joy_t         joy3,
    input  joy_t         joy4,
    input  logic [1:0]   start,
    input  logic [1:0]   coin,
    input  logic         service,
    input  logic         dip_test,
    input  logic [7:0]   dipsw_a,
    input  logic [7:0]   dipsw_b,
    input  logic [7:0]   dipsw_c,
    periph_bus_if.target bus,
    output logic         oki_bank
);

    logic              page_ok;
    logic [7:0]        sys_lo;
    logic [DATA_W-1:0] rd_word;

    // board inputs are active low, bit order as the game expects
    function automatic logic [7:0] ctrl_byte(input joy_t j, input logic has_b3);
        ctrl_byte = {1'b0, has_b3 & ~j[6], ~j[5], ~j[4], ~j[0], ~j[1], ~j[2], ~j[3]};
    endfunction

    assign page_ok = bus.adr.io.page == IO_PAGE;
    assign sys_lo  = {1'b0, ~start[1], ~start[0], ~coin[1], ~coin[0], ~dip_test, 1'b0, ~service};

    always_comb begin
        rd_word = '0;
        if (page_ok) begin
            case (bus.adr.io.port)
                PORT_DSWC: rd_word = {2{dipsw_c}};
                PORT_DSWA: rd_word = {2{dipsw_a}};
                PORT_DSWB: rd_word = {2{dipsw_b}};
                PORT_P1:   rd_word = {2{ctrl_byte(joy1, 1'b0)}};
                PORT_P2:   rd_word = {2{ctrl_byte(joy2, 1'b0)}};
                PORT_P3:   rd_word = {2{ctrl_byte(joy3, 1'b1)}};  // 3rd button on p3/p4
                PORT_P4:   rd_word = {2{ctrl_byte(joy4, 1'b1)}};
                PORT_SYS:  rd_word = {dipsw_c, sys_lo};
                default:   rd_word = '0;                        // bank latch reads back 0
            endcase
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus.ack  <= 1'b0;
            bus.rdat <= '0;
            oki_bank <= 1'b0;
        end else begin
            bus.ack  <= bus.stb;
            bus.rdat <= (bus.stb && !bus.we) ? rd_word : '0;
            // speech sample bank, low lane only
            if (bus.stb && bus.we && page_ok && bus.adr.io.port == PORT_BANK && bus.sel[0]) begin
                oki_bank <= bus.wdat[0];
            end
        end
    end

endmodule

/* logic/main_bus_sys.sv */
`timescale 1ns/1ps

module main_bus_sys
    import sys_pkg::*;
#(
    parameter int WRAM_AW = 15,
    parameter int PAL_AW  = 11
) (
    input  logic               clk96,
    input  logic               reset96,
    input  logic               cyc,
    input  logic               stb,
    input  logic               we,
    input  logic [1:0]         sel,
    input  logic [ADDR_W-1:1]  adr,
    input  logic [DATA_W-1:0]  dat_w,
    output logic [DATA_W-1:0]  dat_r,
    output logic               ack,
    input  joy_t               joy1,
    input  joy_t               joy2,
    input  joy_t               joy3,
    input  joy_t               joy4,
    input  logic [1:0]         start,
    input  logic [1:0]         coin,
    input  logic               service,
    input  logic               dip_test,
    input  logic [7:0]         dipsw_a,
    input  logic [7:0]         dipsw_b,
    input  logic [7:0]         dipsw_c,
    output vdp_op_t            vdp_op,
    input  logic               vdp_ack,
    input  logic [DATA_W-1:0]  vdp_dout,
    input  logic               lvbl,
    output logic               oki_bank,
    input  logic [PAL_AW-1:0]  pal_vid_addr,
    output logic [DATA_W-1:0]  pal_vid_data
);

    periph_bus_if wram_if ();
    periph_bus_if pal_if ();
    periph_bus_if io_if ();
    periph_bus_if vdp_if ();

    bus_decoder u_bus_decoder (
        .clk96, .reset96, .cyc, .stb, .we, .sel, .adr, .dat_w, .dat_r, .ack,
        .wram (wram_if.master),
        .pal  (pal_if.master),
        .io   (io_if.master),
        .vdp  (vdp_if.master)
    );

    work_ram #(.ADDR_W(WRAM_AW)) u_work_ram (.clk96, .reset96, .bus(wram_if.target));

    palette_ram #(.ADDR_W(PAL_AW)) u_palette_ram (
        .clk96, .reset96,
        .vid_addr (pal_vid_addr),
        .bus      (pal_if.target),
        .vid_data (pal_vid_data)
    );

    cabinet_io u_cabinet_io (
        .clk96, .reset96, .joy1, .joy2, .joy3, .joy4, .start, .coin, .service,
        .dip_test, .dipsw_a, .dipsw_b, .dipsw_c,
        .bus (io_if.target),
        .oki_bank
    );

    vdp_cmd u_vdp_cmd (.clk96, .reset96, .vdp_ack, .vdp_dout, .lvbl, .bus(vdp_if.target), .vdp_op);

endmodule

/* logic/palette_ram.sv */
`timescale 1ns/1ps

module palette_ram #(
    parameter int ADDR_W = 11  // word address bits
) (
    input  logic              clk96,
    input  logic              reset96,
    input  logic [ADDR_W-1:0] vid_addr,
    periph_bus_if.target      bus,
    output logic [15:0]       vid_data
);

    logic [15:0]       mem [2**ADDR_W];
    logic [ADDR_W-1:0] word_addr;
    logic [15:0]       q;
    logic              rd_ack;

    assign word_addr = bus.adr.rgn.ofs[ADDR_W:1];  // upper offset bits alias

    always_ff @(posedge clk96) begin
        if (bus.stb && bus.we) begin
            if (bus.sel[0]) begin
                mem[word_addr][7:0] <= bus.wdat[7:0];
            end
            if (bus.sel[1]) begin
                mem[word_addr][15:8] <= bus.wdat[15:8];
            end
        end
        q        <= mem[word_addr];
        vid_data <= mem[vid_addr];  // video side, read every cycle
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus.ack <= 1'b0;
            rd_ack  <= 1'b0;
        end else begin
            bus.ack <= bus.stb;
            rd_ack  <= bus.stb && !bus.we;
        end
    end

    assign bus.rdat = rd_ack ? q : '0;

endmodule

/* logic/periph_bus_if.sv */
`timescale 1ns/1ps

// one decoded channel from the bus front end to a single target
interface periph_bus_if
    import sys_pkg::*;
();

    logic              stb;   // open, matching, not yet acked
    logic              we;
    logic [1:0]        sel;   // byte lanes, [1] is the high byte
    bus_addr_u         adr;
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;  // zero unless a read is being acked
    logic              ack;   // one-cycle pulse

    modport master (
        output stb, we, sel, adr, wdat,
        input  rdat, ack
    );

    modport target (
        input  stb, we, sel, adr, wdat,
        output rdat, ack
    );

endinterface

/* logic/sys_pkg.sv */
package sys_pkg;

    localparam int ADDR_W = 24;  // byte address
    localparam int DATA_W = 16;

    // one byte address, read as region + offset or as i/o page + port
    typedef union packed {
        struct packed {
            logic [7:0]  region;
            logic [15:0] ofs;
        } rgn;
        struct packed {
            logic [11:0] page;
            logic [11:0] port;
        } io;
    } bus_addr_u;

    localparam logic [7:0]  REGION_WRAM = 8'h10;
    localparam logic [3:0]  REGION_VDP  = 4'h3;   // top nibble only
    localparam logic [3:0]  REGION_PAL  = 4'h4;   // top nibble only
    localparam logic [11:0] IO_PAGE     = 12'h700;

    // cabinet i/o ports inside IO_PAGE
    localparam logic [11:0] PORT_DSWC = 12'h000;
    localparam logic [11:0] PORT_DSWA = 12'h004;
    localparam logic [11:0] PORT_DSWB = 12'h008;
    localparam logic [11:0] PORT_P1   = 12'h00C;
    localparam logic [11:0] PORT_P2   = 12'h010;
    localparam logic [11:0] PORT_P3   = 12'h014;
    localparam logic [11:0] PORT_P4   = 12'h018;
    localparam logic [11:0] PORT_SYS  = 12'h01C;
    localparam logic [11:0] PORT_BANK = 12'h030;

    // bit positions in the one-hot op vector
    typedef enum logic [2:0] {
        SELECT_REG, WRITE_REG, WRITE_RAM, READ_RAM_H, READ_RAM_L, SET_RAM_PTR
    } vdp_op_e;

    typedef logic [5:0] vdp_op_t;

    // low byte-address bits of the command port
    localparam logic [3:0] VDP_OFS_PTR    = 4'h0;
    localparam logic [3:0] VDP_OFS_RAM_H  = 4'h4;
    localparam logic [3:0] VDP_OFS_RAM_L  = 4'h6;
    localparam logic [3:0] VDP_OFS_SELECT = 4'h8;
    localparam logic [3:0] VDP_OFS_CTRL   = 4'hC;

    typedef logic [6:0] joy_t;  // active high from the cabinet

endpackage

/* logic/vdp_cmd.sv */
`timescale 1ns/1ps

module vdp_cmd
    import sys_pkg::*;
(
    input  logic              clk96,
    input  logic              reset96,
    input  logic              vdp_ack,
    input  logic [DATA_W-1:0] vdp_dout,
    input  logic              lvbl,
    periph_bus_if.target      bus,
    output vdp_op_t           vdp_op
);

    logic [3:0] ofs;
    vdp_op_t    op_req;
    logic       pending;  // strobe out, waiting on the chip

    assign ofs = bus.adr.rgn.ofs[3:0];

    always_comb begin
        op_req = '0;
        if (bus.we) begin
            case (ofs)
                VDP_OFS_CTRL:                 op_req[WRITE_REG]   = 1'b1;
                VDP_OFS_SELECT:               op_req[SELECT_REG]  = 1'b1;
                VDP_OFS_RAM_H, VDP_OFS_RAM_L: op_req[WRITE_RAM]   = 1'b1;
                VDP_OFS_PTR:                  op_req[SET_RAM_PTR] = 1'b1;
                default: ;
            endcase
        end else begin
            case (ofs)
                VDP_OFS_RAM_H: op_req[READ_RAM_H] = 1'b1;
                VDP_OFS_RAM_L: op_req[READ_RAM_L] = 1'b1;
                default: ;  // status or nothing
            endcase
        end
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            pending  <= 1'b0;
            vdp_op   <= '0;
            bus.ack  <= 1'b0;
            bus.rdat <= '0;
        end else begin
            bus.ack  <= 1'b0;
            bus.rdat <= '0;
            if (pending) begin
                if (vdp_ack) begin
                    pending  <= 1'b0;
                    vdp_op   <= '0;
                    bus.ack  <= 1'b1;
                    bus.rdat <= bus.we ? '0 : vdp_dout;
                end
            end else if (bus.stb) begin
                if (op_req != '0) begin
                    pending <= 1'b1;
                    vdp_op  <= op_req;
                end else begin
                    // status read gives the vblank flag, others just complete
                    bus.ack  <= 1'b1;
                    bus.rdat <= (!bus.we && ofs == VDP_OFS_CTRL) ?
                                {{(DATA_W-1){1'b0}}, !lvbl} : '0;
                end
            end
        end
    end

    a_op_onehot: assert property (@(posedge clk96) disable iff (reset96) $onehot0(vdp_op))
        else $error("several video ops strobed at once");

endmodule

/* logic/work_ram.sv */
`timescale 1ns/1ps

module work_ram #(
    parameter int ADDR_W = 15  // word address bits
) (
    input  logic         clk96,
    input  logic         reset96,
    periph_bus_if.target bus
);

    logic [15:0]       mem [2**ADDR_W];
    logic [ADDR_W-1:0] word_addr;
    logic [15:0]       q;
    logic              rd_ack;  // this ack belongs to a read

    assign word_addr = bus.adr.rgn.ofs[ADDR_W:1];

    always_ff @(posedge clk96) begin
        if (bus.stb && bus.we) begin
            if (bus.sel[0]) begin
                mem[word_addr][7:0] <= bus.wdat[7:0];
            end
            if (bus.sel[1]) begin
                mem[word_addr][15:8] <= bus.wdat[15:8];
            end
        end
        q <= mem[word_addr];  // read-before-write
    end

    always_ff @(posedge clk96 or posedge reset96) begin
        if (reset96) begin
            bus.ack <= 1'b0;
            rd_ack  <= 1'b0;
        end else begin
            bus.ack <= bus.stb;  // stb drops with ack, so one pulse
            rd_ack  <= bus.stb && !bus.we;
        end
    end

    assign bus.rdat = rd_ack ? q : '0;

endmodule

/* run.sh */
#!/bin/sh
# build and run the bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_main_bus_sys -f filelist.f

status=0
out=$(./obj_dir/Vtb_main_bus_sys) || status=$?
printf '%s\n' "$out"
echo "simulator exit status: $status"
printf '%s\n' "$out" | grep -qx 'Testbench passed'

/* verif/tb_main_bus_sys.sv */
`timescale 1ns/1ps

module tb_main_bus_sys
    import sys_pkg::*;
();

    localparam int CLK_NS      = 40;
    localparam int PAL_AW      = 11;
    localparam int WRAM_POOL   = 64;  // words in use at a stride of 517
    localparam int PAL_POOL    = 32;  // stride of 61
    localparam int N_RAND      = 800;
    localparam int N_TOTAL     = N_RAND + WRAM_POOL + PAL_POOL;
    localparam int WATCHDOG_NS = 4 * N_TOTAL * 10 * CLK_NS;
    localparam logic [11:0] IO_PORTS [10] = '{PORT_DSWC, PORT_DSWA, PORT_DSWB, PORT_P1,
        PORT_P2, PORT_P3, PORT_P4, PORT_SYS, PORT_BANK, 12'h024};  // last one is a hole

    logic              clk96;
    logic              reset96;
    logic              cyc, stb, we;
    logic [1:0]        sel;
    logic [ADDR_W-1:1] adr;
    logic [DATA_W-1:0] dat_w, dat_r;
    logic              ack;
    joy_t              joy1, joy2, joy3, joy4;
    logic [1:0]        start, coin;
    logic              service, dip_test;
    logic [7:0]        dipsw_a, dipsw_b, dipsw_c;
    vdp_op_t           vdp_op;
    logic              vdp_ack;
    logic [DATA_W-1:0] vdp_dout;
    logic              lvbl;
    logic              oki_bank;
    logic [PAL_AW-1:0] pal_vid_addr;
    logic [DATA_W-1:0] pal_vid_data;

    // reference model
    logic [DATA_W-1:0] wram_m [int];
    logic [DATA_W-1:0] pal_m [int];
    logic              bank_m;
    int                op_count;   // strobes seen by the responder
    vdp_op_t           last_op;
    logic [DATA_W-1:0] last_dout;

    main_bus_sys #(.WRAM_AW(15), .PAL_AW(PAL_AW)) u_main_bus_sys (.*);

    initial begin
        clk96 = 1'b0;
        forever #(CLK_NS / 2) clk96 = ~clk96;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string what, input logic [DATA_W-1:0] got, exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t ns: %s gave %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_op(input string what, input vdp_op_t got, exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input string what, input logic got, exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    function automatic logic [7:0] player_byte(input joy_t j, input logic p34);
        logic [7:0] b;
        b[7]   = 1'b0;
        b[6]   = p34 ? ~j[6] : 1'b0;  // extra button on players 3 and 4 only
        b[5:4] = ~j[5:4];
        b[3:0] = ~{j[0], j[1], j[2], j[3]};
        return b;
    endfunction

    function automatic logic [DATA_W-1:0] io_expect(input bus_addr_u a);
        logic [7:0] sys_lo;
        sys_lo = {1'b0, ~start[1], ~start[0], ~coin[1], ~coin[0], ~dip_test, 1'b0, ~service};
        if (a.io.page != IO_PAGE) begin
            return '0;
        end
        case (a.io.port)
            PORT_DSWA: return {2{dipsw_a}};
            PORT_DSWB: return {2{dipsw_b}};
            PORT_DSWC: return {2{dipsw_c}};
            PORT_P1:   return {2{player_byte(joy1, 1'b0)}};
            PORT_P2:   return {2{player_byte(joy2, 1'b0)}};
            PORT_P3:   return {2{player_byte(joy3, 1'b1)}};
            PORT_P4:   return {2{player_byte(joy4, 1'b1)}};
            PORT_SYS:  return {dipsw_c, sys_lo};
            default:   return '0;
        endcase
    endfunction

    task automatic change_inputs();
        @(posedge clk96);
        joy1     <= 7'($urandom);
        joy2     <= 7'($urandom);
        joy3     <= 7'($urandom);
        joy4     <= 7'($urandom);
        start    <= 2'($urandom);
        coin     <= 2'($urandom);
        service  <= 1'($urandom);
        dip_test <= 1'($urandom);
        dipsw_a  <= 8'($urandom);
        dipsw_b  <= 8'($urandom);
        dipsw_c  <= 8'($urandom);
        lvbl     <= 1'($urandom);
    endtask

    // one classic cycle held until ack and dropped on the next edge
    task automatic bus_access(input logic wr, input logic [1:0] lanes, input bus_addr_u a,
                              input logic [DATA_W-1:0] wd, input logic fixed_lat,
                              output logic [DATA_W-1:0] rd);
        int waits;
        waits = 0;
        @(posedge clk96);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= wr;
        sel   <= lanes;
        adr   <= {a.rgn.region, a.rgn.ofs[15:1]};
        dat_w <= wd;
        do begin
            @(negedge clk96);
            waits++;
        end while (ack !== 1'b1);
        rd = dat_r;
        if (fixed_lat) begin
            check_bit("ack one cycle after stb", waits == 2, 1'b1);
        end
        @(posedge clk96);
        cyc <= 1'b0;
        stb <= 1'b0;
    endtask

    task automatic ram_access(input logic is_pal);
        int                wa;
        bus_addr_u         a;
        logic              wr;
        logic [1:0]        lanes;
        logic [DATA_W-1:0] wd, rd, word;
        wr    = 1'($urandom);
        lanes = wr ? 2'($urandom_range(3, 1)) : 2'b11;
        wd    = 16'($urandom);
        if (is_pal) begin
            wa   = int'($urandom_range(PAL_POOL - 1)) * 61;
            a    = {4'h4, 4'($urandom), 4'($urandom), 11'(wa), 1'b0};  // upper bits alias
            word = pal_m[wa];
        end else begin
            wa   = int'($urandom_range(WRAM_POOL - 1)) * 517;
            a    = {REGION_WRAM, 15'(wa), 1'b0};
            word = wram_m[wa];
        end
        bus_access(wr, lanes, a, wd, 1'b1, rd);
        if (!wr) begin
            check_word(is_pal ? "palette read" : "work ram read", rd, word);
        end else begin
            if (lanes[0]) word[7:0] = wd[7:0];
            if (lanes[1]) word[15:8] = wd[15:8];
            if (is_pal) pal_m[wa] = word;
            else wram_m[wa] = word;
        end
    endtask

    task automatic check_vid();
        int wa;
        wa = int'($urandom_range(PAL_POOL - 1)) * 61;
        @(posedge clk96);
        pal_vid_addr <= PAL_AW'(wa);
        @(posedge clk96);
        @(negedge clk96);
        check_word("palette video port", pal_vid_data, pal_m[wa]);
    endtask

    task automatic io_access();
        bus_addr_u         a;
        logic              wr;
        logic [1:0]        lanes;
        logic [DATA_W-1:0] wd, rd;
        a.io.page = ($urandom_range(7) == 0) ? 12'h70F : IO_PAGE;  // wrong page now and then
        a.io.port = IO_PORTS[$urandom_range(9)];
        wr    = 1'($urandom);
        lanes = 2'($urandom_range(3, 1));
        wd    = 16'($urandom);
        bus_access(wr, lanes, a, wd, 1'b1, rd);
        if (!wr) begin
            check_word("cabinet port read", rd, io_expect(a));
        end else if (a.io.page == IO_PAGE && a.io.port == PORT_BANK && lanes[0]) begin
            bank_m = wd[0];
        end
    endtask

    task automatic vdp_access();
        bus_addr_u         a;
        logic              wr;
        logic              status_rd;
        logic [DATA_W-1:0] rd, exp_rd;
        vdp_op_t           exp_op;
        a         = {4'h3, 16'($urandom), 4'($urandom_range(7) * 2)};
        wr        = 1'($urandom);
        exp_op    = '0;
        exp_rd    = '0;
        status_rd = 1'b0;
        case ({wr, a.rgn.ofs[3:0]})
            {1'b0, VDP_OFS_RAM_H}:  exp_op[READ_RAM_H] = 1'b1;
            {1'b0, VDP_OFS_RAM_L}:  exp_op[READ_RAM_L] = 1'b1;
            {1'b0, VDP_OFS_CTRL}:   status_rd = 1'b1;  // vblank status
            {1'b1, VDP_OFS_CTRL}:   exp_op[WRITE_REG] = 1'b1;
            {1'b1, VDP_OFS_SELECT}: exp_op[SELECT_REG] = 1'b1;
            {1'b1, VDP_OFS_RAM_H},
            {1'b1, VDP_OFS_RAM_L}:  exp_op[WRITE_RAM] = 1'b1;
            {1'b1, VDP_OFS_PTR}:    exp_op[SET_RAM_PTR] = 1'b1;
            default: ;
        endcase
        op_count = 0;
        bus_access(wr, 2'b11, a, 16'($urandom), exp_op == '0, rd);
        check_bit("one video strobe per op access", op_count == (exp_op != '0), 1'b1);
        if (status_rd) begin
            exp_rd[0] = ~lvbl;  // flag is set while lvbl is low
        end
        if (exp_op != '0) begin
            check_op("video op raised", last_op, exp_op);
            exp_rd = last_dout;
        end
        if (!wr) begin
            check_word("command port read", rd, exp_rd);
        end
    endtask

    task automatic unmapped_access();
        bus_addr_u         a;
        logic              wr;
        logic [DATA_W-1:0] rd;
        do begin
            a = {23'($urandom), 1'b0};
            if ($urandom_range(3) == 0) a.rgn.region = 8'h00;
        end while (a.rgn.region == REGION_WRAM || a.rgn.region[7:4] == REGION_VDP ||
                   a.rgn.region[7:4] == REGION_PAL || a.rgn.region == IO_PAGE[11:4]);
        wr       = 1'($urandom);
        op_count = 0;
        bus_access(wr, 2'($urandom_range(3, 1)), a, 16'($urandom), 1'b1, rd);
        check_bit("no video strobe on unmapped access", op_count == 0, 1'b1);
        if (!wr) begin
            check_word("unmapped read", rd, '0);
        end
    endtask

    // stands in for the graphics chip
    initial begin : vdp_responder
        vdp_op_t held;
        forever begin
            @(negedge clk96);
            if (vdp_op != '0) begin
                held    = vdp_op;
                last_op = held;
                op_count++;
                repeat ($urandom_range(5)) begin
                    @(negedge clk96);
                    check_op("video op held", vdp_op, held);
                end
                @(posedge clk96);
                last_dout = 16'($urandom);
                vdp_ack  <= 1'b1;
                vdp_dout <= last_dout;
                @(negedge clk96);
                check_op("video op held until chip ack", vdp_op, held);
                @(posedge clk96);
                vdp_ack <= 1'b0;
                @(negedge clk96);
                check_op("video op after chip ack", vdp_op, '0);
                check_bit("bus ack as video op drops", ack, 1'b1);
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run("timeout: the bus stopped answering before all accesses were done");
    end

    initial begin : stimulus
        logic [DATA_W-1:0] wd, rd;
        int unsigned       pick;
        void'($urandom(32'h524c_8a01));
        reset96      <= 1'b1;
        cyc          <= 1'b0;
        stb          <= 1'b0;
        we           <= 1'b0;
        sel          <= 2'b00;
        adr          <= '0;
        dat_w        <= '0;
        vdp_ack      <= 1'b0;
        vdp_dout     <= '0;
        pal_vid_addr <= '0;
        {joy1, joy2, joy3, joy4} <= '0;
        {start, coin, service, dip_test, lvbl} <= '1;
        {dipsw_a, dipsw_b, dipsw_c} <= '0;
        bank_m   = 1'b0;
        op_count = 0;
        repeat (8) @(posedge clk96);
        reset96 <= 1'b0;
        // fill the word pools so later partial writes start from known data
        for (int i = 0; i < WRAM_POOL; i++) begin
            wd = 16'($urandom);
            bus_access(1'b1, 2'b11, {REGION_WRAM, 15'(i * 517), 1'b0}, wd, 1'b1, rd);
            wram_m[i * 517] = wd;
        end
        for (int i = 0; i < PAL_POOL; i++) begin
            wd = 16'($urandom);
            bus_access(1'b1, 2'b11, {8'h40, 4'h0, 11'(i * 61), 1'b0}, wd, 1'b1, rd);
            pal_m[i * 61] = wd;
        end
        for (int i = 0; i < N_RAND; i++) begin
            if ($urandom_range(3) == 0) change_inputs();
            pick = $urandom_range(99);
            if (pick < 30) begin
                ram_access(1'b0);
            end else if (pick < 50) begin
                ram_access(1'b1);
                check_vid();
            end else if (pick < 75) begin
                io_access();
            end else if (pick < 90) begin
                vdp_access();
            end else begin
                unmapped_access();
            end
            @(negedge clk96);
            check_bit("ack is a single pulse", ack, 1'b0);
            check_bit("oki bank", oki_bank, bank_m);
        end
        $display("Testbench passed");
        $finish;
    end

endmodule
